// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rop_cop
FILELIST  := verilog.f
BUILD     := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard testbench/*.svh)
SIM     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== rtl/cop_data_ram.sv ====
// Byte-enabled word RAM with one stall cycle per access and an out-of-range error
`timescale 1ns/1ns

module cop_data_ram import rop_pkg::*; #(
    parameter int RAM_WORDS = def_ram_words     // Depth in 32-bit words
) (
    input  logic     clk,
    input  logic     rst_n,             // Async, active low
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int          addr_w     = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam logic [31:0] addr_limit = 32'(RAM_WORDS * 4);  // First unmapped byte

    logic [31:0]       mem [RAM_WORDS];
    logic              busy;            // Second cycle of an access
    logic              in_range;
    logic              access;          // Enabled and mapped
    logic [addr_w-1:0] word_idx;

    // --------------------------------------------------------------------------
    // Address check

    assign in_range = mem_req.addr < addr_limit;
    assign access   = mem_req.cen && in_range;
    assign word_idx = mem_req.addr[addr_w+1:2];

    // --------------------------------------------------------------------------
    // Busy flag

    // Set in the first cycle of an access, clear when it completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= access && !busy;
        end
    end

    // --------------------------------------------------------------------------
    // Storage

    always_ff @(posedge clk) begin
        if (access && busy && mem_req.wen) begin    // Write on the completing edge
            for (int i = 0; i < 4; i++) begin
                if (mem_req.ben[i]) begin
                    mem[word_idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // Response

    always_comb begin
        mem_rsp.stall = access && !busy;            // Exactly one stall cycle
        mem_rsp.error = mem_req.cen && !in_range;   // Never stalls
        mem_rsp.rdata = in_range ? mem[word_idx] : 32'd0;
    end

endmodule

// ==== rtl/rop_ba_cop.sv ====
// Byte-masked co-processor with padded arithmetic, address generation and writeback
`timescale 1ns/1ns

module rop_ba_cop import rop_pkg::*; #(
    parameter logic [63:0] PRNG_SEED = def_prng_seed   // Passed to the LFSR
) (
    input  logic     clk,
    input  logic     rst_n,             // Async, active low
    input  logic     cop_req,           // Host request valid
    input  cop_req_t cop_in,            // Instruction and source registers
    output logic     cop_acc,           // ISE instruction offered
    output logic     cop_rsp,           // Instruction finished this cycle
    output cop_wb_t  cop_wb,            // Register writeback
    output logic     clk_req,           // Clock wanted while a request is up
    output logic     mem_ld_error,
    output logic     mem_st_error,
    output mem_req_t mem_req,           // To the data RAM
    input  mem_rsp_t mem_rsp            // From the data RAM
);

    dec_ops_t    ops;
    logic [31:0] offset;
    logic [4:0]  dec_rd;
    logic [2:0]  dec_rd_byte;

    logic [63:0] prng_out;

    logic [31:0] m_rs1;                 // Source registers masked by the request
    logic [31:0] m_rs2;
    logic [31:0] arith_lhs;
    logic [31:0] arith_rhs;
    logic [31:0] arith_out;
    logic        op_xor;
    logic        op_and;
    logic        op_or;

    logic        mem_op;
    logic        mem_done;              // Access completed or faulted
    logic [31:0] mem_sum;               // Unaligned byte address

    // --------------------------------------------------------------------------
    // Decode and random source

    rop_decode rop_decode_i (
        .cop_req (cop_req),
        .instr   (cop_in.instr),
        .ops     (ops),
        .offset  (offset),
        .rd      (dec_rd),
        .rd_byte (dec_rd_byte)
    );

    rop_prng #(
        .PRNG_SEED (PRNG_SEED)
    ) rop_prng_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rng_en     (1'b1),             // Free running so the padding changes every cycle
        .rng_random (prng_out)
    );

    // --------------------------------------------------------------------------
    // Handshake

    assign clk_req = cop_req;
    assign cop_acc = ops.sb_b || ops.mem_load || ops.arith;
    assign cop_rsp = ops.arith || mem_done;     // Arithmetic answers at once

    // --------------------------------------------------------------------------
    // Padded arithmetic

    assign m_rs1 = cop_in.rs1 & {32{cop_req}};
    assign m_rs2 = cop_in.rs2 & {32{cop_req}};

    // Only the low byte carries data and the rest is random padding
    assign arith_lhs = {prng_out[31:8],  m_rs1[7:0]};
    assign arith_rhs = {prng_out[55:32], m_rs2[7:0]};

    assign op_xor = ops.xor_rb || ops.xor_rbk;
    assign op_and = ops.and_rb || ops.and_rbk;
    assign op_or  = ops.or_rb  || ops.or_rbk;

    always_comb begin
        if (op_xor) begin
            arith_out = arith_lhs ^ arith_rhs;
        end else if (op_and) begin
            arith_out = arith_lhs & arith_rhs;
        end else if (op_or) begin
            arith_out = arith_lhs | arith_rhs;
        end else begin
            arith_out = 32'd0;
        end
    end

    // --------------------------------------------------------------------------
    // Memory access

    assign mem_op  = ops.sb_b || ops.mem_load;
    assign mem_sum = m_rs1 + offset;    // Offset is zero outside memory ops

    always_comb begin
        mem_req.cen   = mem_op;
        mem_req.wen   = ops.sb_b;
        mem_req.addr  = {32{mem_op}} & {mem_sum[31:2], 2'b00};    // Word aligned
        mem_req.ben   = {4{mem_op}} & (4'b0001 << mem_sum[1:0]);  // Lane of the byte
        mem_req.wdata = m_rs2;          // Lane k of rs2 goes to lane k
    end

    // Error ends the access in its first cycle and a clean access waits out the stall
    assign mem_done     = mem_op && (mem_rsp.error || !mem_rsp.stall);
    assign mem_ld_error = ops.mem_load && mem_rsp.error;
    assign mem_st_error = ops.sb_b && mem_rsp.error;

    // --------------------------------------------------------------------------
    // Writeback

    always_comb begin
        cop_wb.rd      = dec_rd;
        cop_wb.rd_byte = dec_rd_byte;
        cop_wb.wdata   = ops.mem_load ? mem_rsp.rdata : arith_out;
        // Only arithmetic and a clean load completion write back
        cop_wb.wen     = ops.arith || (ops.mem_load && mem_done && !mem_rsp.error);
    end

endmodule

// ==== rtl/rop_cop_top.sv ====
// Top level joining the co-processor to its private data RAM
`timescale 1ns/1ns

module rop_cop_top import rop_pkg::*; #(
    parameter logic [63:0] PRNG_SEED = def_prng_seed,  // Padding LFSR reset value
    parameter int          RAM_WORDS = def_ram_words   // Data RAM depth in words
) (
    input  logic     clk,
    input  logic     rst_n,             // Async, active low
    input  logic     cop_req,
    input  cop_req_t cop_in,
    output logic     cop_acc,
    output logic     cop_rsp,
    output cop_wb_t  cop_wb,
    output logic     clk_req,
    output logic     mem_ld_error,
    output logic     mem_st_error
);

    mem_req_t mem_req;                  // Co-processor to RAM
    mem_rsp_t mem_rsp;                  // RAM to co-processor

    rop_ba_cop #(
        .PRNG_SEED (PRNG_SEED)
    ) rop_ba_cop_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cop_req      (cop_req),
        .cop_in       (cop_in),
        .cop_acc      (cop_acc),
        .cop_rsp      (cop_rsp),
        .cop_wb       (cop_wb),
        .clk_req      (clk_req),
        .mem_ld_error (mem_ld_error),
        .mem_st_error (mem_st_error),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp)
    );

    cop_data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) cop_data_ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// ==== rtl/rop_decode.sv ====
// Instruction decoder producing operation flags, memory offset and destination mapping
`timescale 1ns/1ns

module rop_decode import rop_pkg::*; (
    input  logic        cop_req,        // Request valid, gates every flag
    input  rop_instr_u  instr,          // Offered instruction word
    output dec_ops_t    ops,            // One-hot operation flags
    output logic [31:0] offset,         // Sign-extended memory offset
    output logic [4:0]  rd,             // Destination register
    output logic [2:0]  rd_byte         // Destination byte or whole word
);

    logic        in_ise;                // Valid request in the ISE opcode space
    logic        is_rtype;
    logic [6:0]  f7;
    logic [4:0]  fld_rd;                // Raw rd field
    logic [31:0] s_offset;
    logic [31:0] i_offset;

    // --------------------------------------------------------------------------
    // Operation flags

    assign in_ise   = cop_req && (instr.i_fmt.opcode == ise_opcode);
    assign is_rtype = in_ise && (instr.i_fmt.f3 == f3_r);
    assign f7       = instr.i_fmt.imm[11:5];    // Upper half of the I-type immediate

    always_comb begin
        // Store flag read through the S view, the same f3 bits either way
        ops.sb_b      = in_ise && (instr.s_fmt.f3 == f3_sb_b);
        ops.lb_b      = in_ise && (instr.i_fmt.f3 == f3_lb_b);
        ops.lb_bk     = in_ise && (instr.i_fmt.f3 == f3_lb_bk);

        ops.xor_rb    = is_rtype && (f7 == f7_xor_rb);
        ops.xor_rbk   = is_rtype && (f7 == f7_xor_rbk);
        ops.and_rb    = is_rtype && (f7 == f7_and_rb);
        ops.and_rbk   = is_rtype && (f7 == f7_and_rbk);
        ops.or_rb     = is_rtype && (f7 == f7_or_rb);
        ops.or_rbk    = is_rtype && (f7 == f7_or_rbk);   // f7 above 5 matches nothing

        // Summary flags used by the datapath
        ops.rand_keep = ops.lb_bk || ops.xor_rbk || ops.and_rbk || ops.or_rbk;
        ops.mem_load  = ops.lb_b || ops.lb_bk;
        ops.arith     = ops.xor_rb  || ops.xor_rbk ||
                        ops.and_rb  || ops.and_rbk ||
                        ops.or_rb   || ops.or_rbk;
    end

    // --------------------------------------------------------------------------
    // Memory offset

    assign s_offset = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign i_offset = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};

    always_comb begin
        if (ops.sb_b) begin
            offset = s_offset;
        end else if (ops.mem_load) begin
            offset = i_offset;
        end else begin
            offset = 32'd0;             // Quiet when no memory op
        end
    end

    // --------------------------------------------------------------------------
    // Destination mapping

    assign fld_rd = instr.i_fmt.rd;

    always_comb begin
        if (ops.rand_keep) begin
            // Keep-random results land in a0..a7 as a full word
            rd      = 5'd10 + {2'b00, fld_rd[2:0]};
            rd_byte = 3'b100;
        end else begin
            rd      = fld_rd;
            rd_byte = {1'b0, fld_rd[4:3]};  // Top two rd bits pick the byte
        end
    end

endmodule

// ==== rtl/rop_pkg.sv ====
// ISE opcode constants, instruction union, port structs and default parameters
package rop_pkg;

    // --------------------------------------------------------------------------
    // Instruction encodings

    localparam logic [6:0] ise_opcode   = 7'b0101011;  // Custom major opcode of the ISE

    localparam logic [2:0] f3_sb_b      = 3'b000;      // SB.B
    localparam logic [2:0] f3_r         = 3'b001;      // All R-type arithmetic
    localparam logic [2:0] f3_lb_b      = 3'b010;      // LB.B
    localparam logic [2:0] f3_lb_bk     = 3'b011;      // LB.BK

    localparam logic [6:0] f7_xor_rb    = 7'd0;
    localparam logic [6:0] f7_xor_rbk   = 7'd1;
    localparam logic [6:0] f7_and_rb    = 7'd2;
    localparam logic [6:0] f7_and_rbk   = 7'd3;
    localparam logic [6:0] f7_or_rb     = 7'd4;
    localparam logic [6:0] f7_or_rbk    = 7'd5;        // Highest valid f7 code

    // Defaults picked up by the top level parameters
    localparam logic [63:0] def_prng_seed = 64'h9e37_79b9_7f4a_7c15;
    localparam int          def_ram_words = 256;       // Depth in 32-bit words

    // --------------------------------------------------------------------------
    // Instruction word views

    // Store layout, offset split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;     // Offset bits 11..5
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] f3;
        logic [4:0] imm_lo;     // Offset bits 4..0
        logic [6:0] opcode;
    } rop_s_fmt_t;

    // Load and R-type layout, f7 sits in imm[11:5]
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rop_i_fmt_t;

    typedef union packed {
        rop_s_fmt_t s_fmt;
        rop_i_fmt_t i_fmt;
    } rop_instr_u;

    // --------------------------------------------------------------------------
    // Port bundles

    typedef struct packed {
        rop_instr_u  instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } cop_req_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [2:0]  rd_byte;   // 1xx is whole word, 0bb selects byte bb
        logic [31:0] wdata;
        logic        wen;
    } cop_wb_t;

    typedef struct packed {
        logic        cen;
        logic        wen;
        logic [3:0]  ben;       // One-hot byte lane
        logic [31:0] addr;      // Word aligned
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        stall;
        logic        error;
        logic [31:0] rdata;
    } mem_rsp_t;

    // Decoder result, at most one of the nine operation flags is set
    typedef struct packed {
        logic sb_b;
        logic lb_b;
        logic lb_bk;
        logic xor_rb;
        logic xor_rbk;
        logic and_rb;
        logic and_rbk;
        logic or_rb;
        logic or_rbk;
        logic rand_keep;        // Write back the whole padded word
        logic mem_load;         // LB.B or LB.BK
        logic arith;            // Any of the six bytewise ops
    } dec_ops_t;

endpackage

// ==== rtl/rop_prng.sv ====
// 64-bit maximal-length Galois LFSR that supplies the operand padding bits
`timescale 1ns/1ns

module rop_prng import rop_pkg::*; #(
    parameter logic [63:0] PRNG_SEED = def_prng_seed  // State after reset
) (
    input  logic        clk,
    input  logic        rst_n,          // Async, active low
    input  logic        rng_en,         // Step the LFSR this cycle
    output logic [63:0] rng_random      // Current LFSR state
);

    // Feedback polynomial x^64 + x^63 + x^61 + x^60 + 1
    localparam logic [63:0] taps = 64'hd800_0000_0000_0000;

    // An all-zero state never leaves zero, so fall back to one
    localparam logic [63:0] seed_safe = (PRNG_SEED == 64'd0) ? 64'd1 : PRNG_SEED;

    logic [63:0] lfsr_q;
    logic [63:0] lfsr_d;

    // --------------------------------------------------------------------------
    // Next state

    always_comb begin
        lfsr_d = {1'b0, lfsr_q[63:1]};      // Shift towards bit 0
        if (lfsr_q[0]) begin
            lfsr_d = lfsr_d ^ taps;         // Fold the outgoing bit back in
        end
    end

    // --------------------------------------------------------------------------
    // State register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= seed_safe;
        end else if (rng_en) begin
            lfsr_q <= lfsr_d;
        end
    end

    assign rng_random = lfsr_q;

endmodule

// ==== testbench/tb_rop_checks.svh ====
// Concurrent handshake assertions and the tasks that check and report results
`ifndef TB_ROP_CHECKS_SVH
`define TB_ROP_CHECKS_SVH

// --------------------------------------------------------------------------
// Handshake properties

// Outputs stay quiet with no request offered, during reset too
idle_quiet: assert property (@(posedge clk)
    !cop_req |-> !cop_acc && !cop_rsp && !cop_wb.wen && !clk_req)
    else begin
        $display("assertion idle_quiet: DUT output active without a request at %0t", $time);
        errors++;
    end

// Response or writeback only for an accepted instruction
rsp_needs_acc: assert property (@(posedge clk) disable iff (!rst_n)
    (cop_rsp || cop_wb.wen) |-> cop_acc)
    else begin
        $display("assertion rsp_needs_acc: response for a rejected instruction at %0t", $time);
        errors++;
    end

// Accepted but unanswered means one stall cycle, then done
one_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (cop_acc && !cop_rsp) |=> cop_rsp)
    else begin
        $display("assertion one_stall: memory access took more than one cycle at %0t", $time);
        errors++;
    end

// Fault ends the access at once and writes nothing back
fault_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_ld_error || mem_st_error) |-> cop_rsp && !cop_wb.wen)
    else begin
        $display("assertion fault_rsp: memory error without a clean response at %0t", $time);
        errors++;
    end

// --------------------------------------------------------------------------
// Value checks and per-test summary

task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("mismatch %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_idle();
    check_hex("cop_acc", 32'(cop_acc), 32'd0);
    check_hex("cop_rsp", 32'(cop_rsp), 32'd0);
    check_hex("cop_wb.wen", 32'(cop_wb.wen), 32'd0);
    check_hex("clk_req", 32'(clk_req), 32'd0);
endtask

task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors != err_start) begin
        tests_failed++;
    end
    $display("%s: %s, %0d errors", name, (errors == err_start) ? "ok" : "FAILED",
             errors - err_start);
endtask

`endif

// ==== testbench/tb_rop_cop.sv ====
// Testbench for the co-processor top with stimulus, shadow memory and test sequence
`timescale 1ns/1ns

module tb_rop_cop import rop_pkg::*; ();

    localparam int          ram_words   = 256;
    localparam logic [63:0] dut_seed    = 64'h5bd1_e995_2a6c_8f31;
    localparam int          rsp_timeout = 20;   // Cycles before giving up on cop_rsp

    logic        clk;
    logic        rst_n;
    logic        cop_req;
    cop_req_t    cop_in;
    logic        cop_acc;
    logic        cop_rsp;
    cop_wb_t     cop_wb;
    logic        clk_req;
    logic        mem_ld_error;
    logic        mem_st_error;

    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic [31:0] seed         = 32'h8af9597e;
    logic [31:0] shadow [ram_words];    // Expected RAM contents

    `include "tb_rop_checks.svh"

    rop_cop_top #(
        .PRNG_SEED (dut_seed),
        .RAM_WORDS (ram_words)
    ) rop_cop_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cop_req      (cop_req),
        .cop_in       (cop_in),
        .cop_acc      (cop_acc),
        .cop_rsp      (cop_rsp),
        .cop_wb       (cop_wb),
        .clk_req      (clk_req),
        .mem_ld_error (mem_ld_error),
        .mem_st_error (mem_st_error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    // --------------------------------------------------------------------------
    // Stimulus helpers

    function automatic logic [31:0] xorshift32();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    // Random 12-bit offset, sign-extended, sign chosen by the caller
    function automatic logic [31:0] pick_offset(input logic neg);
        logic [31:0] r;
        r = xorshift32();
        return {{21{neg}}, r[10:0]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rd);
        return {f7, 5'd0, 5'd0, f3_r, rd, ise_opcode};
    endfunction

    function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [11:0] imm,
                                             input logic [4:0] rd);
        return {imm, 5'd0, f3, rd, ise_opcode};
    endfunction

    function automatic logic [31:0] enc_store(input logic [11:0] imm);
        return {imm[11:5], 5'd0, 5'd0, f3_sb_b, imm[4:0], ise_opcode};   // Offset split
    endfunction

    task automatic next_drive();
        @(posedge clk);
        #1;                             // Inputs change just after the edge
    endtask

    // Hold a request until cop_rsp, sampling each cycle at the falling edge
    task automatic issue(input logic [31:0] instr, input logic [31:0] rs1,
                         input logic [31:0] rs2, output int lat, output cop_wb_t wb,
                         output logic wen_any, output logic [1:0] err);
        cop_req      = 1'b1;
        cop_in.instr = instr;
        cop_in.rs1   = rs1;
        cop_in.rs2   = rs2;
        lat          = 0;
        wen_any      = 1'b0;
        @(negedge clk);
        while (!cop_rsp && lat < rsp_timeout) begin
            wen_any = wen_any | cop_wb.wen;
            @(negedge clk);
            lat++;
        end
        if (!cop_rsp) begin
            $display("timeout: no response from the DUT within %0d cycles", rsp_timeout);
            errors++;
        end
        wen_any = wen_any | cop_wb.wen;
        wb      = cop_wb;
        err     = {mem_ld_error, mem_st_error};
        next_drive();
        cop_req = 1'b0;
        cop_in  = '0;
    endtask

    // One-cycle offer of an instruction that must be ignored
    task automatic offer_reject(input logic [31:0] instr);
        cop_req      = 1'b1;
        cop_in.instr = instr;
        cop_in.rs1   = xorshift32();
        cop_in.rs2   = xorshift32();
        @(negedge clk);
        check_hex("cop_acc", 32'(cop_acc), 32'd0);
        check_hex("cop_rsp", 32'(cop_rsp), 32'd0);
        check_hex("cop_wb.wen", 32'(cop_wb.wen), 32'd0);
        next_drive();
        cop_req = 1'b0;
        cop_in  = '0;
    endtask

    // --------------------------------------------------------------------------
    // Test sequence

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] high;
        logic [31:0] off;
        logic [31:0] rs2;
        logic [7:0]  exp_b;
        logic [6:0]  f7;
        logic        keep;
        logic        wen_any;
        logic [1:0]  err;
        cop_wb_t     wb;
        int          lat;
        int          e0;
        int          idx;
        int          last_idx;

        rst_n   = 1'b0;
        cop_req = 1'b0;
        cop_in  = '0;
        last_idx = 0;

        // Reset state, then two idle cycles
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_idle();
        end
        next_drive();
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        next_drive();
        report_test("reset_state", e0);

        // Arithmetic bytes and destination mapping
        e0 = errors;
        for (int i = 0; i < 24; i++) begin
            r    = xorshift32();
            a    = xorshift32();
            b    = xorshift32();
            f7   = 7'(i % 6);
            keep = f7[0];               // Odd codes are the .RBK forms
            case (f7)
                f7_xor_rb, f7_xor_rbk: exp_b = a[7:0] ^ b[7:0];
                f7_and_rb, f7_and_rbk: exp_b = a[7:0] & b[7:0];
                default:               exp_b = a[7:0] | b[7:0];
            endcase
            issue(enc_r(f7, r[4:0]), a, b, lat, wb, wen_any, err);
            check_hex("arith latency", 32'(lat), 32'd0);
            check_hex("cop_wb.wen", 32'(wb.wen), 32'd1);
            check_hex("cop_wb.wdata[7:0]", 32'(wb.wdata[7:0]), 32'(exp_b));
            check_hex("cop_wb.rd", 32'(wb.rd),
                      keep ? 32'(5'd10 + {2'b00, r[2:0]}) : 32'(r[4:0]));
            check_hex("cop_wb.rd_byte", 32'(wb.rd_byte), keep ? 32'h4 : 32'(r[4:3]));
        end
        report_test("arith_rd_map", e0);

        // Foreign opcodes, then R-type with f7 above 5
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            r = xorshift32();
            if (i < 3) begin
                if (r[6:0] == ise_opcode) begin
                    r[0] = ~r[0];
                end
                offer_reject(r);
            end else begin
                f7 = (r[31:25] < 7'd6) ? r[31:25] + 7'd6 : r[31:25];
                offer_reject(enc_r(f7, r[4:0]));
            end
        end
        report_test("reject", e0);

        // Fill all four lanes of a word, then read it back both ways
        e0 = errors;
        for (int w = 0; w < 6; w++) begin
            r   = xorshift32();
            idx = int'(r[15:0]) % ram_words;
            for (int k = 0; k < 4; k++) begin
                addr = 32'(idx * 4 + k);
                off  = pick_offset(k[0]);   // Both offset signs
                rs2  = xorshift32();
                issue(enc_store(off[11:0]), addr - off, rs2, lat, wb, wen_any, err);
                shadow[idx][8*k +: 8] = rs2[8*k +: 8];
                check_hex("store latency", 32'(lat), 32'd1);
                check_hex("store cop_wb.wen", 32'(wen_any), 32'd0);
                check_hex("store mem errors", 32'(err), 32'd0);
            end
            for (int j = 0; j < 2; j++) begin
                r    = xorshift32();
                addr = 32'(idx * 4) + {30'd0, r[1:0]};
                off  = pick_offset(r[2]);
                issue(enc_load((j == 0) ? f3_lb_b : f3_lb_bk, off[11:0], r[7:3]),
                      addr - off, 32'd0, lat, wb, wen_any, err);
                check_hex("load latency", 32'(lat), 32'd1);
                check_hex("load cop_wb.wen", 32'(wb.wen), 32'd1);
                check_hex("load cop_wb.wdata", wb.wdata, shadow[idx]);
                check_hex("load mem errors", 32'(err), 32'd0);
            end
            last_idx = idx;
        end
        report_test("store_load", e0);

        // Out-of-range accesses alias onto a known word and must leave it alone
        e0 = errors;
        for (int j = 0; j < 3; j++) begin
            r    = xorshift32();
            addr = 32'(last_idx * 4) + {30'd0, r[1:0]};
            high = addr + 32'(ram_words * 4 * (j + 1));
            off  = pick_offset(r[2]);
            issue(enc_store(off[11:0]), high - off, ~shadow[last_idx], lat, wb, wen_any, err);
            check_hex("oor store errors", 32'(err), 32'h1);
            check_hex("oor store latency", 32'(lat), 32'd0);
            check_hex("oor store cop_wb.wen", 32'(wen_any), 32'd0);
            issue(enc_load(f3_lb_b, off[11:0], r[12:8]), high - off, 32'd0,
                  lat, wb, wen_any, err);
            check_hex("oor load errors", 32'(err), 32'h2);
            check_hex("oor load latency", 32'(lat), 32'd0);
            check_hex("oor load cop_wb.wen", 32'(wen_any), 32'd0);
            issue(enc_load(f3_lb_b, off[11:0], r[12:8]), addr - off, 32'd0,
                  lat, wb, wen_any, err);
            check_hex("reload cop_wb.wdata", wb.wdata, shadow[last_idx]);
        end
        report_test("mem_errors", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+testbench
rtl/rop_pkg.sv
rtl/rop_prng.sv
rtl/rop_decode.sv
rtl/rop_ba_cop.sv
rtl/cop_data_ram.sv
rtl/rop_cop_top.sv
testbench/tb_rop_cop.sv
